//--- bench/hsq_tb.sv
`timescale 1ns/10ps
`include "hsq_defs.svh"

module hsq_tb;
    import hsq_pkg::*;

    localparam int N_TESTS   = 9;
    localparam int MAX_BURST = 12;
    // longest finite ack delay in the table
    localparam int MAX_DELAY = 20;
    // consumer never answers this word
    localparam int NEVER     = 255;

    logic  clk_i = 1'b0;
    logic  rst_ni;
    logic  flush_i;
    logic  push_i;
    data_t data_i;
    logic  full_o;
    cnt_t  usage_o;
    logic  req_o;
    logic  ack_i;
    data_t data_o;
    logic  timeout_o;

    // stimulus table with one row per test
    string tab_name  [N_TESTS];
    int    tab_len   [N_TESTS];
    bit    tab_flush [N_TESTS];
    bit    tab_full  [N_TESTS];
    data_t tab_data  [N_TESTS][MAX_BURST];
    int    tab_delay [N_TESTS][MAX_BURST];

    // accepted words not yet taken by the egress side in push order
    data_t pend_data[$];
    int    pend_delay[$];

    // consumer model state
    logic  req_seen    = 1'b0;
    logic  delivered   = 1'b0;
    logic  cur_deliver = 1'b1;
    data_t cur_data    = '0;
    int    cur_delay   = 0;
    int    wait_cnt    = 0;
    logic  exp_timeout = 1'b0;
    logic  full_seen   = 1'b0;

    int errors    = 0;
    int checks    = 0;
    int wd_cycles = 0;

    hsq_top dut_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .flush_i   (flush_i),
        .push_i    (push_i),
        .data_i    (data_i),
        .full_o    (full_o),
        .usage_o   (usage_o),
        .req_o     (req_o),
        .ack_i     (ack_i),
        .data_o    (data_o),
        .timeout_o (timeout_o)
    );

    // 10 ns clock
    always #5 clk_i = ~clk_i;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // fill one row with counting data and one ack delay for every word
    task automatic set_entry(input int t, input string name, input int len,
                             input int dly, input bit flush, input bit full);
        tab_name[t]  = name;
        tab_len[t]   = len;
        tab_flush[t] = flush;
        tab_full[t]  = full;
        for (int i = 0; i < MAX_BURST; i++) begin
            tab_data[t][i]  = data_t'((t + 1) * 256 + i);
            tab_delay[t][i] = dly;
        end
    endtask

    task automatic build_table();
        set_entry(0, "burst order", 5, 1, 1'b0, 1'b0);
        tab_delay[0][1] = 0;
        tab_delay[0][2] = 3;
        tab_delay[0][4] = 6;
        // slow consumer lets the producer run into full
        set_entry(1, "fill to full", `HSQ_DEPTH + 3, 12, 1'b0, 1'b1);
        // last allowed delay is still delivered
        set_entry(2, "timeout drop", 5, 2, 1'b0, 1'b0);
        tab_delay[2][1] = NEVER;
        tab_delay[2][2] = MAX_DELAY;
        tab_delay[2][3] = `HSQ_ACK_TIMEOUT;
        set_entry(3, "flush", 6, 10, 1'b1, 1'b0);
        set_entry(4, "after flush", 3, 0, 1'b0, 1'b0);
        tab_delay[4][1] = 4;
        for (int t = 5; t < N_TESTS; t++) begin
            set_entry(t, "random", $urandom_range(1, MAX_BURST), 0, 1'b0, 1'b0);
            for (int i = 0; i < MAX_BURST; i++) begin
                tab_data[t][i]  = data_t'($urandom);
                tab_delay[t][i] = $urandom_range(0, 10);
            end
        end
    endtask

    // producer holds the word back while full, then pushes for one cycle
    task automatic push_word(input data_t w, input int dly);
        @(negedge clk_i);
        while (full_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        push_i <= 1'b1;
        data_i <= w;
        // full was low and no other push is pending, so it is taken here
        @(posedge clk_i);
        push_i <= 1'b0;
        pend_data.push_back(w);
        pend_delay.push_back(dly);
    endtask

    task automatic flush_queue();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        // queue emptied on this edge while a word already taken stays in flight
        pend_data.delete();
        pend_delay.delete();
        exp_timeout = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk_i);
        while (pend_data.size() != 0 || req_o || ack_i || usage_o != '0) begin
            @(negedge clk_i);
        end
        // let the consumer finish the last handshake bookkeeping
        repeat (2) @(negedge clk_i);
    endtask

    // consumer model samples on the falling edge and answers on the rising edge
    always begin
        @(negedge clk_i);
        if (rst_ni) begin
            if (full_o) begin
                full_seen = 1'b1;
            end
            if (req_o && !req_seen) begin
                // head word left the queue on the last edge
                if (pend_data.size() == 0) begin
                    $display("req_o rose while no accepted word was waiting at %0t", $time);
                    errors++;
                    cur_data    = data_o;
                    cur_delay   = 0;
                    cur_deliver = 1'b1;
                end else begin
                    cur_data    = pend_data.pop_front();
                    cur_delay   = pend_delay.pop_front();
                    cur_deliver = (cur_delay <= `HSQ_ACK_TIMEOUT);
                    check_val("data_o", data_o, cur_data);
                end
                delivered = 1'b0;
                wait_cnt  = 0;
            end else if (req_o) begin
                check_val("data_o", data_o, cur_data);
            end
            if (req_o && ack_i) begin
                // req must drop on the edge right after ack is seen
                if (delivered) begin
                    $display("req_o stayed high a cycle after ack_i at %0t", $time);
                    errors++;
                end
                delivered = 1'b1;
            end
            if (!req_o && req_seen) begin
                check_val("delivered", delivered, cur_deliver);
                if (!cur_deliver) begin
                    exp_timeout = 1'b1;
                    check_val("timeout_o", timeout_o, 1'b1);
                end
            end
            // fill level is the number of accepted words not yet taken
            check_val("usage_o", usage_o, pend_data.size());
            req_seen = req_o;
        end
        @(posedge clk_i);
        if (req_seen && !ack_i) begin
            // ack rises on edge max(delay, 1) after the req rise
            if (wait_cnt + 1 >= cur_delay) begin
                ack_i <= 1'b1;
            end else begin
                wait_cnt++;
            end
        end else if (!req_seen && ack_i) begin
            ack_i <= 1'b0;
        end
    end

    // watchdog sized from the table
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk_i);
        $display("timeout, run did not finish within %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main_flow
        int err0;
        int burst_sum;
        rst_ni  = 1'b0;
        flush_i = 1'b0;
        push_i  = 1'b0;
        data_i  = '0;
        ack_i   = 1'b0;
        void'($urandom(32'hcdc3));
        build_table();
        burst_sum = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            burst_sum += tab_len[t];
        end
        wd_cycles = burst_sum * (MAX_DELAY + 8);

        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        err0 = errors;
        check_val("req_o", req_o, 1'b0);
        check_val("timeout_o", timeout_o, 1'b0);
        check_val("full_o", full_o, 1'b0);
        check_val("usage_o", usage_o, 0);
        check_val("data_o", data_o, 0);
        $display("test 0 %-13s mismatches %0d", "reset", errors - err0);

        for (int t = 0; t < N_TESTS; t++) begin
            err0      = errors;
            full_seen = 1'b0;
            for (int i = 0; i < tab_len[t]; i++) begin
                push_word(tab_data[t][i], tab_delay[t][i]);
            end
            if (tab_flush[t]) begin
                // next row pushes at once and those words must come next
                flush_queue();
                @(negedge clk_i);
                check_val("usage_o", usage_o, 0);
                check_val("timeout_o", timeout_o, 1'b0);
            end else begin
                wait_idle();
                check_val("timeout_o", timeout_o, exp_timeout);
            end
            if (tab_full[t]) begin
                check_val("full_o seen", full_seen, 1'b1);
            end
            $display("test %0d %-13s mismatches %0d", t + 1, tab_name[t], errors - err0);
        end

        $display("tests %0d, checks %0d, errors %0d", N_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog/fifo_rd_if.sv
`timescale 1ns/10ps

interface fifo_rd_if;
    import hsq_pkg::*;

    // head removal request from the consumer of the queue
    logic  pop;
    // no word stored
    logic  empty;
    // current head word, valid while empty is low
    data_t rdata;
    // number of stored words
    cnt_t  usage;

    // queue side
    modport fifo (
        input  pop,
        output empty,
        output rdata,
        output usage
    );

    // egress state machine side, usage is not needed there
    modport egress (
        input  empty,
        input  rdata,
        output pop
    );

endinterface

//--- verilog/hsq_ack_timer.sv
`timescale 1ns/10ps
`include "hsq_defs.svh"

module hsq_ack_timer (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic run_i,
    output logic expired_o
);
    import hsq_pkg::*;

    // cycles spent so far in the current wait
    tmo_t cnt_q;
    logic at_limit;

    assign at_limit = (cnt_q == tmo_t'(`HSQ_ACK_TIMEOUT));

    // the count lags run by one edge, so it is masked with run
    assign expired_o = run_i && at_limit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            // a new wait always starts from zero
            cnt_q <= '0;
        end else if (!at_limit) begin
            cnt_q <= cnt_q + tmo_t'(1);
        end
        // otherwise hold at the limit until run drops
    end

    // expiry needs a whole timeout window with run held high,
    // so it can never show while the egress side is not waiting
    a_expired_in_window : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        expired_o |-> run_i && $past(run_i, `HSQ_ACK_TIMEOUT)
    ) else $error("hsq_ack_timer: expiry outside a full wait window");

endmodule

//--- verilog/hsq_defs.svh
`ifndef HSQ_DEFS_SVH
`define HSQ_DEFS_SVH

// width of one command word in bits
`define HSQ_DATA_WIDTH 16

// number of queue entries
// any value of two or more works, not only powers of two
`define HSQ_DEPTH 8

// cycles the egress side waits for ack high
// once this many cycles have passed the word is dropped
`define HSQ_ACK_TIMEOUT 16

`endif

//--- verilog/hsq_egress_fsm.sv
`timescale 1ns/10ps

module hsq_egress_fsm (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           flush_i,
    fifo_rd_if.egress      rd,
    input  logic           expired_i,
    output logic           run_o,
    output logic           req_o,
    input  logic           ack_i,
    output hsq_pkg::data_t data_o,
    output logic           timeout_o
);
    import hsq_pkg::*;

    egress_state_e state_q;
    egress_state_e state_d;

    // word under delivery, held from the pop until the next pop
    data_t hold_q;

    // sticky drop flag
    logic timeout_q;

    // start of a handshake in this cycle
    logic take;
    // word dropped in this cycle
    logic give_up;

    // start only with a word waiting and the consumer back at ack low
    // a flush in the same cycle empties the queue, so no word is taken
    assign take = (state_q == IDLE) && !rd.empty && !ack_i && !flush_i;

    // pop and load happen on the same edge
    assign rd.pop = take;

    // an ack on the last allowed cycle still counts as delivered
    assign give_up = (state_q == REQ_HI) && !ack_i && expired_i;

    // req high for the whole wait, the timer runs alongside it
    assign req_o     = (state_q == REQ_HI);
    assign run_o     = (state_q == REQ_HI);
    assign data_o    = hold_q;
    assign timeout_o = timeout_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take) begin
                    state_d = REQ_HI;
                end
            end
            REQ_HI: begin
                // ack or timeout both drop req on the next edge
                if (ack_i || expired_i) begin
                    state_d = REQ_LO;
                end
            end
            REQ_LO: begin
                // a late ack for a dropped word is absorbed here
                if (!ack_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            hold_q  <= '0;
        end else begin
            state_q <= state_d;
            if (take) begin
                hold_q <= rd.rdata;
            end
        end
    end

    // flag stays until flush
    // a drop in the flush cycle is a new event and sets it again
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timeout_q <= 1'b0;
        end else if (give_up) begin
            timeout_q <= 1'b1;
        end else if (flush_i) begin
            timeout_q <= 1'b0;
        end
    end

    // consumer sees one word for the whole req high phase
    a_data_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_o |=> (!req_o || $stable(data_o))
    ) else $error("hsq_egress_fsm: data_o changed while req_o high");

    // four-phase rule, the consumer must have ack low before a new req
    a_req_rise_ack_low : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(req_o) |-> !ack_i
    ) else $error("hsq_egress_fsm: req_o rose while ack_i high");

endmodule

//--- verilog/hsq_fifo.sv
`timescale 1ns/10ps
`include "hsq_defs.svh"

module hsq_fifo (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           flush_i,
    input  logic           push_i,
    input  hsq_pkg::data_t data_i,
    output logic           full_o,
    fifo_rd_if.fifo        rd
);
    import hsq_pkg::*;

    // word storage
    data_t mem_q [`HSQ_DEPTH];

    // circular buffer pointers
    ptr_t wr_ptr_q;
    ptr_t wr_ptr_d;
    ptr_t rd_ptr_q;
    ptr_t rd_ptr_d;

    // fill count, drives full, empty and usage
    cnt_t cnt_q;
    cnt_t cnt_d;

    // accepted transfers in this cycle
    logic push_ok;
    logic pop_ok;

    // step a pointer by one and wrap at the last slot
    // for a power of two depth the compare is just the all ones value
    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_t n;
        if (p == ptr_t'(`HSQ_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + ptr_t'(1);
        end
        return n;
    endfunction

    // status flags straight from the registered count
    assign full_o   = (cnt_q == cnt_t'(`HSQ_DEPTH));
    assign rd.empty = (cnt_q == '0);
    assign rd.usage = cnt_q;

    // no fall-through, head comes from storage only
    assign rd.rdata = mem_q[rd_ptr_q];

    // a push on full or a pop on empty is ignored here
    // and flagged by the checks below
    assign push_ok = push_i && !full_o;
    assign pop_ok  = rd.pop && !rd.empty;

    always_comb begin
        wr_ptr_d = wr_ptr_q;
        rd_ptr_d = rd_ptr_q;
        cnt_d    = cnt_q;

        if (push_ok) begin
            wr_ptr_d = ptr_inc(wr_ptr_q);
        end

        if (pop_ok) begin
            rd_ptr_d = ptr_inc(rd_ptr_q);
        end

        // push and pop together leave the count alone
        case ({push_ok, pop_ok})
            2'b10: begin
                cnt_d = cnt_q + cnt_t'(1);
            end
            2'b01: begin
                cnt_d = cnt_q - cnt_t'(1);
            end
            default: begin
                cnt_d = cnt_q;
            end
        endcase
    end

    // pointers and count, flush drops everything stored
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush wins over a push or pop in the same cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_d;
            rd_ptr_q <= rd_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // storage write at the current tail
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // producer has to hold off while full is high
    a_no_push_on_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        full_o |-> !push_i
    ) else $error("hsq_fifo: push while the queue is full");

    // egress side may only pop a stored word
    a_no_pop_on_empty : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rd.empty |-> !rd.pop
    ) else $error("hsq_fifo: pop while the queue is empty");

endmodule

//--- verilog/hsq_pkg.sv
`include "hsq_defs.svh"

package hsq_pkg;

    // one command word as pushed by the producer
    typedef logic [`HSQ_DATA_WIDTH-1:0] data_t;

    // read or write slot index inside the circular buffer
    typedef logic [$clog2(`HSQ_DEPTH)-1:0] ptr_t;

    // fill count, one bit wider so a full queue fits
    typedef logic [$clog2(`HSQ_DEPTH):0] cnt_t;

    // ack wait counter, must be able to hold the timeout value itself
    typedef logic [$clog2(`HSQ_ACK_TIMEOUT+1)-1:0] tmo_t;

    // egress handshake phases
    typedef enum logic [1:0] {
        IDLE,
        REQ_HI,
        REQ_LO
    } egress_state_e;

endpackage

//--- verilog/hsq_top.sv
`timescale 1ns/10ps

module hsq_top (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           flush_i,
    input  logic           push_i,
    input  hsq_pkg::data_t data_i,
    output logic           full_o,
    output hsq_pkg::cnt_t  usage_o,
    output logic           req_o,
    input  logic           ack_i,
    output hsq_pkg::data_t data_o,
    output logic           timeout_o
);

    // queue read side toward the egress state machine
    fifo_rd_if rd_if ();

    // ack wait timer handshake
    logic run;
    logic expired;

    // fill level leaves the design straight from the interface
    assign usage_o = rd_if.usage;

    // producer side queue
    hsq_fifo fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (push_i),
        .data_i  (data_i),
        .full_o  (full_o),
        .rd      (rd_if)
    );

    // four-phase sender toward the consumer
    hsq_egress_fsm egress_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .flush_i   (flush_i),
        .rd        (rd_if),
        .expired_i (expired),
        .run_o     (run),
        .req_o     (req_o),
        .ack_i     (ack_i),
        .data_o    (data_o),
        .timeout_o (timeout_o)
    );

    // watches each wait for ack high
    hsq_ack_timer timer_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .run_i     (run),
        .expired_o (expired)
    );

endmodule

//--- vlog.f
+incdir+verilog
verilog/hsq_pkg.sv
verilog/fifo_rd_if.sv
verilog/hsq_fifo.sv
verilog/hsq_ack_timer.sv
verilog/hsq_egress_fsm.sv
verilog/hsq_top.sv
bench/hsq_tb.sv
